/* fabric_pkg.sv */
// ----------------------------------------
// Fabric shared definitions
// Bus types, address map, boot ROM image
// and response status codes
// ----------------------------------------
package fabric_pkg;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    // Bit per privilege encoding, bit 2 unused
    typedef logic [3:0]  perm_t;

    parameter int unsigned IDX_W = 16;
    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_e;

    typedef enum logic [1:0] {
        REGION_ROM,
        REGION_RAM,
        REGION_NONE
    } region_e;

    typedef enum logic [1:0] {
        STATUS_OK,
        STATUS_DENIED,
        STATUS_DECERR,
        STATUS_RDONLY
    } status_e;

    // ----------------------------------------
    // Address map and boot ROM
    // ----------------------------------------
    parameter addr_t       ROM_BASE  = 32'h0001_0000;
    parameter int unsigned ROM_WORDS = 8;
    parameter addr_t       RAM_BASE  = 32'h8000_0000;

    // Small boot stub, jumps into RAM
    parameter data_t ROM_IMAGE [ROM_WORDS] = '{
        32'h0000_0297,
        32'h0202_8593,
        32'hf140_2573,
        32'h0182_b283,
        32'h0002_8067,
        32'h0000_0000,
        32'h8000_0000,
        32'h0000_0000
    };

    parameter int unsigned NUM_PERM_REGIONS = 2;
    parameter perm_t       PERM_RESET       = 4'b1000;

    // ----------------------------------------
    // Pipeline payloads
    // ----------------------------------------
    typedef struct packed {
        addr_t     addr;
        data_t     wdata;
        strb_t     be;
        logic      we;
        priv_lvl_e priv;
    } bus_req_t;

    typedef struct packed {
        addr_t     addr;
        data_t     wdata;
        strb_t     be;
        logic      we;
        priv_lvl_e priv;
        region_e   region;
        status_e   status;
        idx_t      idx;
    } dec_req_t;

    typedef struct packed {
        status_e status;
        addr_t   addr;
        data_t   rdata;
    } mem_out_t;

    typedef struct packed {
        status_e status;
        data_t   rdata;
    } bus_resp_t;

endpackage

/* addr_decoder.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Address decoder and access check
// Maps each request onto ROM, RAM or no region,
// checks the per-region privilege table and
// registers the request with its status
// ----------------------------------------
module addr_decoder #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 req_valid_i,
    input  fabric_pkg::bus_req_t req_i,
    input  logic                 cfg_valid_i,
    input  fabric_pkg::region_e  cfg_region_i,
    input  fabric_pkg::perm_t    cfg_perm_i,
    output logic                 dec_valid_o,
    output fabric_pkg::dec_req_t dec_req_o
);

    localparam fabric_pkg::addr_t ROM_LIMIT =
        fabric_pkg::ROM_BASE + fabric_pkg::addr_t'(fabric_pkg::ROM_WORDS * 4);
    localparam fabric_pkg::addr_t RAM_LIMIT =
        fabric_pkg::RAM_BASE + fabric_pkg::addr_t'(RAM_WORDS * 4);

    fabric_pkg::perm_t   perm_q [fabric_pkg::NUM_PERM_REGIONS];
    fabric_pkg::region_e region;
    fabric_pkg::addr_t   offset;
    fabric_pkg::perm_t   perm_sel;
    fabric_pkg::status_e status;
    logic                rom_hit;
    logic                ram_hit;

    // ----------------------------------------
    // Permission table
    // ----------------------------------------
    // ROM and RAM entries differ in bit 0 of the region code
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < fabric_pkg::NUM_PERM_REGIONS; r++) begin
                perm_q[r] <= fabric_pkg::PERM_RESET;
            end
        end else if (cfg_valid_i && cfg_region_i != fabric_pkg::REGION_NONE) begin
            perm_q[cfg_region_i[0]] <= cfg_perm_i;
        end
    end

    // ----------------------------------------
    // Decode and check
    // ----------------------------------------
    always_comb begin
        rom_hit = (req_i.addr >= fabric_pkg::ROM_BASE) && (req_i.addr < ROM_LIMIT);
        ram_hit = (req_i.addr >= fabric_pkg::RAM_BASE) && (req_i.addr < RAM_LIMIT);
        region  = fabric_pkg::REGION_NONE;
        offset  = '0;
        if (rom_hit) begin
            region = fabric_pkg::REGION_ROM;
            offset = req_i.addr - fabric_pkg::ROM_BASE;
        end else if (ram_hit) begin
            region = fabric_pkg::REGION_RAM;
            offset = req_i.addr - fabric_pkg::RAM_BASE;
        end
        perm_sel = (region == fabric_pkg::REGION_NONE) ? '0 : perm_q[region[0]];

        // Rule order matters
        if (region == fabric_pkg::REGION_NONE) begin
            status = fabric_pkg::STATUS_DECERR;
        end else if (!perm_sel[req_i.priv]) begin
            status = fabric_pkg::STATUS_DENIED;
        end else if (region == fabric_pkg::REGION_ROM && req_i.we) begin
            status = fabric_pkg::STATUS_RDONLY;
        end else begin
            status = fabric_pkg::STATUS_OK;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            dec_req_o.addr   <= req_i.addr;
            dec_req_o.wdata  <= req_i.wdata;
            dec_req_o.be     <= req_i.be;
            dec_req_o.we     <= req_i.we;
            dec_req_o.priv   <= req_i.priv;
            dec_req_o.region <= region;
            dec_req_o.status <= status;
            // Byte offset to word index
            dec_req_o.idx    <= offset[fabric_pkg::IDX_W+1:2];
        end
    end

    cfg_region_legal: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cfg_valid_i |-> cfg_region_i != fabric_pkg::REGION_NONE
    );

endmodule

/* mem_targets.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Memory targets
// Byte-enabled RAM and fixed boot ROM,
// both with registered read data
// ----------------------------------------
module mem_targets #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 dec_valid_i,
    input  fabric_pkg::dec_req_t dec_req_i,
    output logic                 mem_valid_o,
    output fabric_pkg::mem_out_t mem_out_o
);

    localparam int unsigned RAM_AW = $clog2(RAM_WORDS);
    localparam int unsigned ROM_AW = $clog2(fabric_pkg::ROM_WORDS);
    localparam int unsigned STRB_W = $bits(fabric_pkg::strb_t);

    fabric_pkg::data_t ram_q [RAM_WORDS];
    fabric_pkg::data_t rd_data;
    logic              acc_ok;
    logic              ram_wr;

    assign acc_ok = dec_valid_i && dec_req_i.status == fabric_pkg::STATUS_OK;
    assign ram_wr = acc_ok && dec_req_i.we && dec_req_i.region == fabric_pkg::REGION_RAM;

    // ----------------------------------------
    // RAM write port
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (ram_wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (dec_req_i.be[b]) begin
                    ram_q[dec_req_i.idx[RAM_AW-1:0]][8*b +: 8] <= dec_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read mux, zero for writes and failed checks
    always_comb begin
        rd_data = '0;
        if (acc_ok && !dec_req_i.we) begin
            if (dec_req_i.region == fabric_pkg::REGION_ROM) begin
                rd_data = fabric_pkg::ROM_IMAGE[dec_req_i.idx[ROM_AW-1:0]];
            end else if (dec_req_i.region == fabric_pkg::REGION_RAM) begin
                rd_data = ram_q[dec_req_i.idx[RAM_AW-1:0]];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_valid_o <= 1'b0;
        end else begin
            mem_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            mem_out_o.status <= dec_req_i.status;
            mem_out_o.addr   <= dec_req_i.addr;
            mem_out_o.rdata  <= rd_data;
        end
    end

    // Decoder never passes an unmapped access as OK
    ok_has_region: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dec_valid_i && dec_req_i.status == fabric_pkg::STATUS_OK
            |-> dec_req_i.region != fabric_pkg::REGION_NONE
    );

endmodule

/* resp_stage.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Response and fault stage
// Registers the bus response and tracks the
// latest failing address and a failure count
// ----------------------------------------
module resp_stage (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  mem_valid_i,
    input  fabric_pkg::mem_out_t  mem_out_i,
    output logic                  resp_valid_o,
    output fabric_pkg::bus_resp_t resp_o,
    output fabric_pkg::addr_t     fault_addr_o,
    output logic [7:0]            fault_count_o
);

    logic fault;

    assign fault = mem_valid_i && mem_out_i.status != fabric_pkg::STATUS_OK;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_o  <= 1'b0;
            fault_addr_o  <= '0;
            fault_count_o <= '0;
        end else begin
            resp_valid_o <= mem_valid_i;
            if (fault) begin
                fault_addr_o <= mem_out_i.addr;
                // Saturate at 255
                if (fault_count_o != 8'hff) begin
                    fault_count_o <= fault_count_o + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_valid_i) begin
            resp_o.status <= mem_out_i.status;
            resp_o.rdata  <= (mem_out_i.status == fabric_pkg::STATUS_OK) ?
                             mem_out_i.rdata : '0;
        end
    end

    // Back-to-back responses need back-to-back memory results
    resp_burst_sourced: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        resp_valid_o && $past(resp_valid_o)
            |-> $past(mem_valid_i, 1) && $past(mem_valid_i, 2)
    );

endmodule

/* fabric_top.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Access-controlled memory fabric
// Decode and check, memories, then response,
// three cycles from request to response
// ----------------------------------------
module fabric_top #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  req_valid_i,
    input  fabric_pkg::bus_req_t  req_i,
    input  logic                  cfg_valid_i,
    input  fabric_pkg::region_e   cfg_region_i,
    input  fabric_pkg::perm_t     cfg_perm_i,
    output logic                  resp_valid_o,
    output fabric_pkg::bus_resp_t resp_o,
    output fabric_pkg::addr_t     fault_addr_o,
    output logic [7:0]            fault_count_o
);

    logic                 dec_valid;
    fabric_pkg::dec_req_t dec_req;
    logic                 mem_valid;
    fabric_pkg::mem_out_t mem_out;

    addr_decoder #(
        .RAM_WORDS ( RAM_WORDS )
    ) i_addr_decoder (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .req_valid_i  ( req_valid_i  ),
        .req_i        ( req_i        ),
        .cfg_valid_i  ( cfg_valid_i  ),
        .cfg_region_i ( cfg_region_i ),
        .cfg_perm_i   ( cfg_perm_i   ),
        .dec_valid_o  ( dec_valid    ),
        .dec_req_o    ( dec_req      )
    );

    mem_targets #(
        .RAM_WORDS ( RAM_WORDS )
    ) i_mem_targets (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .dec_valid_i ( dec_valid ),
        .dec_req_i   ( dec_req   ),
        .mem_valid_o ( mem_valid ),
        .mem_out_o   ( mem_out   )
    );

    resp_stage i_resp_stage (
        .clk_i         ( clk_i         ),
        .arst_n_i      ( arst_n_i      ),
        .mem_valid_i   ( mem_valid     ),
        .mem_out_i     ( mem_out       ),
        .resp_valid_o  ( resp_valid_o  ),
        .resp_o        ( resp_o        ),
        .fault_addr_o  ( fault_addr_o  ),
        .fault_count_o ( fault_count_o )
    );

endmodule

/* tb_fabric.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Fabric testbench
// Drives requests and permission updates,
// checks responses against a reference model
// ----------------------------------------
module tb_fabric;

    localparam int unsigned RAM_WORDS = 256;
    localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);
    localparam int          NUM_REQS  = 64;
    // Three cycles per request covers issue, idle gaps and pipeline drain
    localparam int          WDOG_CYC  = 3 + NUM_REQS * 3 + 50;

    typedef struct packed {
        fabric_pkg::bus_resp_t resp;
        fabric_pkg::addr_t     faddr;
        logic [7:0]            fcount;
    } expect_t;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  req_valid_i;
    fabric_pkg::bus_req_t  req_i;
    logic                  cfg_valid_i;
    fabric_pkg::region_e   cfg_region_i;
    fabric_pkg::perm_t     cfg_perm_i;
    logic                  resp_valid_o;
    fabric_pkg::bus_resp_t resp_o;
    fabric_pkg::addr_t     fault_addr_o;
    logic [7:0]            fault_count_o;

    // Reference model state
    fabric_pkg::data_t     ram_m [RAM_WORDS];
    fabric_pkg::perm_t     perm_rom_m = fabric_pkg::PERM_RESET;
    fabric_pkg::perm_t     perm_ram_m = fabric_pkg::PERM_RESET;
    fabric_pkg::addr_t     faddr_m    = '0;
    logic [7:0]            fcount_m   = '0;
    expect_t               exp_q [$];
    expect_t               exp_cur    = '0;
    // Request strobe delayed by the pipeline depth
    logic [2:0]            req_hist   = '0;
    logic [31:0]           rng        = 32'hc3e86f0f;
    logic [7:0]            idx_list [8];
    int                    value_errors = 0;
    int                    order_errors = 0;

    fabric_top #(
        .RAM_WORDS ( RAM_WORDS )
    ) dut0 (
        .clk_i         ( clk_i         ),
        .arst_n_i      ( arst_n_i      ),
        .req_valid_i   ( req_valid_i   ),
        .req_i         ( req_i         ),
        .cfg_valid_i   ( cfg_valid_i   ),
        .cfg_region_i  ( cfg_region_i  ),
        .cfg_perm_i    ( cfg_perm_i    ),
        .resp_valid_o  ( resp_valid_o  ),
        .resp_o        ( resp_o        ),
        .fault_addr_o  ( fault_addr_o  ),
        .fault_count_o ( fault_count_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic model_request(input fabric_pkg::bus_req_t r);
        fabric_pkg::perm_t   perm;
        fabric_pkg::status_e st;
        expect_t             e;
        logic                is_rom;
        logic                is_ram;
        logic [RAM_AW-1:0]   ri;
        is_rom = r.addr >= fabric_pkg::ROM_BASE &&
                 r.addr < fabric_pkg::ROM_BASE + fabric_pkg::ROM_WORDS * 4;
        is_ram = r.addr >= fabric_pkg::RAM_BASE &&
                 r.addr < fabric_pkg::RAM_BASE + RAM_WORDS * 4;
        ri     = r.addr[RAM_AW+1:2];
        perm   = is_rom ? perm_rom_m : perm_ram_m;
        e      = '0;
        if (!is_rom && !is_ram) begin
            st = fabric_pkg::STATUS_DECERR;
        end else if (!perm[r.priv]) begin
            st = fabric_pkg::STATUS_DENIED;
        end else if (is_rom && r.we) begin
            st = fabric_pkg::STATUS_RDONLY;
        end else begin
            st = fabric_pkg::STATUS_OK;
        end
        if (st == fabric_pkg::STATUS_OK && !r.we) begin
            e.resp.rdata = is_rom ? fabric_pkg::ROM_IMAGE[r.addr[4:2]] : ram_m[ri];
        end
        if (st == fabric_pkg::STATUS_OK && r.we && is_ram) begin
            for (int b = 0; b < 4; b++) begin
                if (r.be[b]) begin
                    ram_m[ri][8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
        end
        if (st != fabric_pkg::STATUS_OK) begin
            faddr_m = r.addr;
            if (fcount_m != 8'hff) begin
                fcount_m = fcount_m + 8'd1;
            end
        end
        e.resp.status = st;
        e.faddr       = faddr_m;
        e.fcount      = fcount_m;
        exp_q.push_back(e);
    endtask

    task automatic issue_req(input fabric_pkg::addr_t addr, input fabric_pkg::data_t wdata,
                             input fabric_pkg::strb_t be, input logic we,
                             input fabric_pkg::priv_lvl_e priv);
        @(posedge clk_i);
        #2;
        cfg_valid_i = 1'b0;
        req_valid_i = 1'b1;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        req_i.be    = be;
        req_i.we    = we;
        req_i.priv  = priv;
        model_request(req_i);
    endtask

    task automatic set_perm(input fabric_pkg::region_e region, input fabric_pkg::perm_t perm);
        @(posedge clk_i);
        #2;
        req_valid_i  = 1'b0;
        cfg_valid_i  = 1'b1;
        cfg_region_i = region;
        cfg_perm_i   = perm;
        if (region == fabric_pkg::REGION_ROM) begin
            perm_rom_m = perm;
        end else if (region == fabric_pkg::REGION_RAM) begin
            perm_ram_m = perm;
        end
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk_i);
        #2;
        req_valid_i = 1'b0;
        cfg_valid_i = 1'b0;
        repeat (n) @(posedge clk_i);
    endtask

    always @(posedge clk_i) begin
        req_hist <= {req_hist[1:0], req_valid_i};
    end

    // Expected values move to the next response between edges
    always @(negedge clk_i) begin
        if (arst_n_i && resp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("%0t: response seen with no request outstanding", $time);
                order_errors++;
            end else begin
                exp_cur = exp_q.pop_front();
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    resp_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        resp_valid_o == req_hist[2])
        else begin
            $display("ERROR %0t resp_valid_o got %b expected %b", $time,
                     $sampled(resp_valid_o), $sampled(req_hist[2]));
            order_errors++;
        end

    resp_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        resp_valid_o |-> resp_o == exp_cur.resp)
        else begin
            $display("ERROR %0t resp_o got %h expected %h", $time,
                     $sampled(resp_o), $sampled(exp_cur.resp));
            value_errors++;
        end

    fault_addr_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fault_addr_o == exp_cur.faddr)
        else begin
            $display("ERROR %0t fault_addr_o got %h expected %h", $time,
                     $sampled(fault_addr_o), $sampled(exp_cur.faddr));
            value_errors++;
        end

    fault_count_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fault_count_o == exp_cur.fcount)
        else begin
            $display("ERROR %0t fault_count_o got %0d expected %0d", $time,
                     $sampled(fault_count_o), $sampled(exp_cur.fcount));
            value_errors++;
        end

    initial begin : watchdog
        repeat (WDOG_CYC) @(posedge clk_i);
        $display("Timeout: test sequence did not complete within %0d cycles", WDOG_CYC);
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0]       rnd;
        fabric_pkg::addr_t a0;
        arst_n_i     = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        cfg_valid_i  = 1'b0;
        cfg_region_i = fabric_pkg::REGION_ROM;
        cfg_perm_i   = '0;
        repeat (3) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        idle_cycles(4);

        // Back-to-back M accesses
        issue_req(fabric_pkg::RAM_BASE, 32'h1234_5678, 4'hf, 1'b1, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::RAM_BASE, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::ROM_BASE + 32'd4, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::RAM_BASE + 32'd4, 32'hcafe_f00d, 4'hf, 1'b1, fabric_pkg::PRIV_M);

        // Full writes, then byte-enabled merges, then reads
        for (int i = 0; i < 8; i++) begin
            rnd         = next_rand();
            idx_list[i] = rnd[9:2];
            issue_req(fabric_pkg::RAM_BASE + {22'd0, rnd[9:0]}, next_rand(), 4'hf, 1'b1,
                      fabric_pkg::PRIV_M);
        end
        for (int i = 0; i < 8; i++) begin
            rnd = next_rand();
            issue_req(fabric_pkg::RAM_BASE + {22'd0, idx_list[i], rnd[1:0]}, next_rand(),
                      rnd[7:4], 1'b1, fabric_pkg::PRIV_M);
        end
        for (int i = 0; i < 8; i++) begin
            rnd = next_rand();
            issue_req(fabric_pkg::RAM_BASE + {22'd0, idx_list[i], rnd[1:0]}, '0,
                      rnd[7:4], 1'b0, fabric_pkg::PRIV_M);
        end

        // Boot ROM image and write protection
        for (int i = 0; i < 8; i++) begin
            issue_req(fabric_pkg::ROM_BASE + 32'(4 * i), '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        end
        issue_req(fabric_pkg::ROM_BASE + 32'd8, 32'hdead_beef, 4'hf, 1'b1, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::ROM_BASE + 32'd8, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);

        // Unmapped addresses
        issue_req(32'h0000_0000, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::ROM_BASE - 32'd4, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::ROM_BASE + 32'd32, 32'h1, 4'hf, 1'b1, fabric_pkg::PRIV_M);
        issue_req(fabric_pkg::RAM_BASE + 32'd1024, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        rnd = next_rand();
        issue_req({2'b01, rnd[29:0]}, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        idle_cycles(2);

        // Lower privileges before and after granting U on RAM
        a0 = fabric_pkg::RAM_BASE + {22'd0, idx_list[0], 2'b00};
        issue_req(a0, 32'h5555_aaaa, 4'hf, 1'b1, fabric_pkg::PRIV_U);
        issue_req(a0, 32'h3333_cccc, 4'hf, 1'b1, fabric_pkg::PRIV_S);
        issue_req(a0, '0, 4'hf, 1'b0, fabric_pkg::PRIV_S);
        issue_req(a0, '0, 4'hf, 1'b0, fabric_pkg::PRIV_M);
        set_perm(fabric_pkg::REGION_RAM, 4'b1001);
        issue_req(a0, 32'h5555_aaaa, 4'hf, 1'b1, fabric_pkg::PRIV_U);
        issue_req(a0, '0, 4'hf, 1'b0, fabric_pkg::PRIV_U);
        issue_req(a0, '0, 4'hf, 1'b0, fabric_pkg::PRIV_S);
        issue_req(fabric_pkg::ROM_BASE, '0, 4'hf, 1'b0, fabric_pkg::PRIV_U);
        idle_cycles(1);

        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (3) @(posedge clk_i);
        $display("Errors: value %0d, order %0d", value_errors, order_errors);
        if (value_errors + order_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
fabric_pkg.sv
addr_decoder.sv
mem_targets.sv
resp_stage.sv
fabric_top.sv
tb_fabric.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fabric -f project.f -o tb_fabric_sim

# Exit status of the simulator is not used, the log decides
./obj_dir/tb_fabric_sim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
